// ==== rtl/bus_map_pkg.sv ====
// Address map, widths and index types of the demo system bus
// Every region is a power of two in size and aligned to its size
package bus_map_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  typedef enum logic [0:0] {
    HOST_CORE = 1'b0, // Highest priority
    HOST_DBG  = 1'b1
  } bus_host_e;

  typedef enum logic [1:0] {
    DEV_RAM   = 2'd0,
    DEV_GPIO  = 2'd1,
    DEV_TIMER = 2'd2
  } bus_device_e;

  localparam int unsigned NR_HOSTS   = 2;
  localparam int unsigned NR_DEVICES = 3;

  localparam logic [ADDR_W-1:0] RAM_START   = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] RAM_SIZE    = 4 * 1024;
  localparam logic [ADDR_W-1:0] RAM_MASK    = ~(RAM_SIZE - 1);
  localparam logic [ADDR_W-1:0] GPIO_START  = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] GPIO_SIZE   = 4 * 1024;
  localparam logic [ADDR_W-1:0] GPIO_MASK   = ~(GPIO_SIZE - 1);
  localparam logic [ADDR_W-1:0] TIMER_START = 32'h8000_2000;
  localparam logic [ADDR_W-1:0] TIMER_SIZE  = 4 * 1024;
  localparam logic [ADDR_W-1:0] TIMER_MASK  = ~(TIMER_SIZE - 1);

  // Decode tables, in bus_device_e order
  localparam logic [ADDR_W-1:0] DEV_BASE [NR_DEVICES] = '{RAM_START, GPIO_START, TIMER_START};
  localparam logic [ADDR_W-1:0] DEV_MASK [NR_DEVICES] = '{RAM_MASK, GPIO_MASK, TIMER_MASK};

  // Byte-lane merge of a bus write into a register
  function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_val,
                                                 input logic [DATA_W-1:0] new_val,
                                                 input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// ==== rtl/periph_pkg.sv ====
// Register layout of the GPIO and timer devices
// Offsets are bytes within a 4 KiB region, only OFS_W low address bits decode
package periph_pkg;

  localparam int unsigned OFS_W = 12;

  // GPIO
  localparam int unsigned GPI_W = 8;
  localparam int unsigned GPO_W = 16;

  localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 12'h000;
  localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 12'h004;

  // Timer
  localparam logic [OFS_W-1:0] TIMER_MTIME_OFS    = 12'h000;
  localparam logic [OFS_W-1:0] TIMER_MTIMECMP_OFS = 12'h004;

  localparam logic [31:0] TIMER_CMP_RESET = '1; // Compare never reached after reset

endpackage

// ==== rtl/bus_if.sv ====
// One bus link, either host to arbiter or arbiter to device
// Devices always accept, so gnt only matters on the host side
`timescale 1ns/1ps

interface bus_if import bus_map_pkg::*; ();

  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] addr;
  logic              we;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata;

  logic              rvalid; // One cycle after the grant
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport host (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

  modport ctrl (
    output req, addr, we, be, wdata,
    input  rvalid, rdata, err
  );

  modport dev (
    input  req, addr, we, be, wdata,
    output rvalid, rdata, err
  );

endinterface

// ==== rtl/bus_arbiter.sv ====
// Fixed-priority arbiter and address decoder, core host wins over debug
// Grant is combinational, the response comes back exactly one cycle later
`timescale 1ns/1ps

module bus_arbiter import bus_map_pkg::*; (
  input  logic clk_sys_i,
  input  logic rst_sys_ni,

  bus_if.host  hosts_io [NR_HOSTS],
  bus_if.ctrl  devs_io  [NR_DEVICES]
);

  logic [NR_HOSTS-1:0] host_req;
  logic [ADDR_W-1:0]   host_addr  [NR_HOSTS];
  logic                host_we    [NR_HOSTS];
  logic [BE_W-1:0]     host_be    [NR_HOSTS];
  logic [DATA_W-1:0]   host_wdata [NR_HOSTS];

  logic [NR_DEVICES-1:0] dev_rvalid;
  logic [NR_DEVICES-1:0] dev_err;
  logic [DATA_W-1:0]     dev_rdata [NR_DEVICES];

  logic              any_req;
  bus_host_e         sel_host;
  logic [ADDR_W-1:0] sel_addr;
  logic [NR_DEVICES-1:0] dev_hit;
  bus_device_e       dev_sel;
  logic              unmapped;

  bus_host_e   host_q;
  bus_device_e dev_q;
  logic        unmapped_q;

  logic              rsp_valid;
  logic              rsp_err;
  logic [DATA_W-1:0] rsp_rdata;

  assign any_req  = |host_req;
  assign sel_host = host_req[HOST_CORE] ? HOST_CORE : HOST_DBG;
  assign sel_addr = host_addr[sel_host];

  // Regions never overlap, so at most one hit
  always_comb begin
    dev_hit = '0;
    dev_sel = DEV_RAM;
    for (int d = 0; d < NR_DEVICES; d++) begin
      if ((sel_addr & DEV_MASK[d]) == DEV_BASE[d]) begin
        dev_hit[d] = 1'b1;
        dev_sel    = bus_device_e'(d);
      end
    end
  end

  assign unmapped = any_req & ~|dev_hit; // Answered here with err

  for (genvar d = 0; d < NR_DEVICES; d++) begin : g_dev
    assign devs_io[d].req   = any_req & dev_hit[d];
    assign devs_io[d].addr  = sel_addr;
    assign devs_io[d].we    = host_we[sel_host];
    assign devs_io[d].be    = host_be[sel_host];
    assign devs_io[d].wdata = host_wdata[sel_host];
    assign dev_rvalid[d]    = devs_io[d].rvalid;
    assign dev_rdata[d]     = devs_io[d].rdata;
    assign dev_err[d]       = devs_io[d].err;
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      host_q     <= HOST_CORE;
      dev_q      <= DEV_RAM;
      unmapped_q <= 1'b0;
    end else begin
      if (any_req) begin
        host_q <= sel_host;
        dev_q  <= dev_sel;
      end
      unmapped_q <= unmapped;
    end
  end

  // Only the device granted last cycle can have rvalid high now
  assign rsp_valid = unmapped_q | dev_rvalid[dev_q];
  assign rsp_err   = unmapped_q | dev_err[dev_q];
  assign rsp_rdata = unmapped_q ? '0 : dev_rdata[dev_q];

  for (genvar h = 0; h < NR_HOSTS; h++) begin : g_host
    logic own_rsp;

    assign host_req[h]   = hosts_io[h].req;
    assign host_addr[h]  = hosts_io[h].addr;
    assign host_we[h]    = hosts_io[h].we;
    assign host_be[h]    = hosts_io[h].be;
    assign host_wdata[h] = hosts_io[h].wdata;

    assign own_rsp = rsp_valid & (int'(host_q) == h);

    assign hosts_io[h].gnt    = any_req & (int'(sel_host) == h);
    assign hosts_io[h].rvalid = own_rsp;
    assign hosts_io[h].err    = own_rsp & rsp_err;
    assign hosts_io[h].rdata  = own_rsp ? rsp_rdata : '0;
  end

endmodule

// ==== rtl/ram_device.sv ====
// Single-port word RAM, contents are undefined until written
// Only the word index bits of the address decode, the region wraps above that
`timescale 1ns/1ps

module ram_device import bus_map_pkg::*; #(
  parameter int unsigned DEPTH_WORDS = RAM_SIZE / BE_W
) (
  input  logic clk_sys_i,
  input  logic rst_sys_ni,

  bus_if.dev   bus_io
);

  localparam int unsigned IDX_W = $clog2(DEPTH_WORDS);

  logic [DATA_W-1:0] mem [DEPTH_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  assign word_idx = bus_io.addr[IDX_W+1:2]; // Byte address to word index

  always_ff @(posedge clk_sys_i) begin
    if (bus_io.req) begin
      if (bus_io.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (bus_io.be[b]) mem[word_idx][8*b +: 8] <= bus_io.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[word_idx]; // Old data on a write
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_io.req;
    end
  end

  assign bus_io.rvalid = rvalid_q;
  assign bus_io.rdata  = rdata_q;
  assign bus_io.err    = 1'b0;

endmodule

// ==== rtl/gpio_device.sv ====
// GPIO with a byte-writable output register and synchronized inputs
// A gp_i read shows the pins as they were two cycles before the request
`timescale 1ns/1ps

module gpio_device import bus_map_pkg::*, periph_pkg::*; (
  input  logic             clk_sys_i,
  input  logic             rst_sys_ni,

  bus_if.dev               bus_io,

  input  logic [GPI_W-1:0] gp_i,
  output logic [GPO_W-1:0] gp_o
);

  logic [OFS_W-1:0]  ofs;
  logic              wr_out;
  logic [GPI_W-1:0]  gp_meta_q;
  logic [GPI_W-1:0]  gp_sync_q;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  assign ofs    = bus_io.addr[OFS_W-1:0];
  assign wr_out = bus_io.req & bus_io.we & (ofs == GPIO_OUT_OFS);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o      <= '0;
      gp_meta_q <= '0;
      gp_sync_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      gp_meta_q <= gp_i; // Two-flop synchronizer
      gp_sync_q <= gp_meta_q;
      rvalid_q  <= bus_io.req;
      if (wr_out) gp_o <= GPO_W'(be_merge(DATA_W'(gp_o), bus_io.wdata, bus_io.be));
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_io.req) begin
      case (ofs)
        GPIO_OUT_OFS: rdata_q <= DATA_W'(gp_o);
        GPIO_IN_OFS:  rdata_q <= DATA_W'(gp_sync_q);
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign bus_io.rvalid = rvalid_q;
  assign bus_io.rdata  = rdata_q;
  assign bus_io.err    = 1'b0; // Unknown offsets read as zero

endmodule

// ==== rtl/timer_device.sv ====
// Compare timer with a 32-bit mtime that runs every cycle
// The interrupt is a registered level and lags the compare by one cycle
`timescale 1ns/1ps

module timer_device import bus_map_pkg::*, periph_pkg::*; (
  input  logic clk_sys_i,
  input  logic rst_sys_ni,

  bus_if.dev   bus_io,

  output logic timer_irq_o
);

  logic [OFS_W-1:0]  ofs;
  logic              sel_mtime;
  logic              sel_cmp;
  logic              wr_mtime;
  logic              wr_cmp;
  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic              err_q;

  assign ofs       = bus_io.addr[OFS_W-1:0];
  assign sel_mtime = (ofs == TIMER_MTIME_OFS);
  assign sel_cmp   = (ofs == TIMER_MTIMECMP_OFS);
  assign wr_mtime  = bus_io.req & bus_io.we & sel_mtime;
  assign wr_cmp    = bus_io.req & bus_io.we & sel_cmp;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= TIMER_CMP_RESET;
      timer_irq_o <= 1'b0;
      rvalid_q    <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      // A bus write wins over the increment
      if (wr_mtime) begin
        mtime_q <= be_merge(mtime_q, bus_io.wdata, bus_io.be);
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_cmp) mtimecmp_q <= be_merge(mtimecmp_q, bus_io.wdata, bus_io.be);

      timer_irq_o <= (mtime_q >= mtimecmp_q);
      rvalid_q    <= bus_io.req;
      err_q       <= bus_io.req & ~(sel_mtime | sel_cmp); // Undecoded offset
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_io.req) begin
      if (sel_mtime) begin
        rdata_q <= mtime_q;
      end else if (sel_cmp) begin
        rdata_q <= mtimecmp_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus_io.rvalid = rvalid_q;
  assign bus_io.rdata  = rdata_q;
  assign bus_io.err    = err_q;

endmodule

// ==== rtl/demo_system.sv ====
// Bus subsystem of the demo: two hosts, RAM, GPIO and timer
// Hosts hold a request and its fields until they see gnt
`timescale 1ns/1ps

module demo_system import bus_map_pkg::*, periph_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,

  input  logic              core_req_i,
  output logic              core_gnt_o,
  input  logic [ADDR_W-1:0] core_addr_i,
  input  logic              core_we_i,
  input  logic [BE_W-1:0]   core_be_i,
  input  logic [DATA_W-1:0] core_wdata_i,
  output logic              core_rvalid_o,
  output logic [DATA_W-1:0] core_rdata_o,
  output logic              core_err_o,

  input  logic              dbg_req_i,
  output logic              dbg_gnt_o,
  input  logic [ADDR_W-1:0] dbg_addr_i,
  input  logic              dbg_we_i,
  input  logic [BE_W-1:0]   dbg_be_i,
  input  logic [DATA_W-1:0] dbg_wdata_i,
  output logic              dbg_rvalid_o,
  output logic [DATA_W-1:0] dbg_rdata_o,
  output logic              dbg_err_o,

  input  logic [GPI_W-1:0]  gp_i,
  output logic [GPO_W-1:0]  gp_o,
  output logic              timer_irq_o
);

  bus_if host_bus [NR_HOSTS] ();
  bus_if dev_bus  [NR_DEVICES] ();

  // Core data port
  assign host_bus[HOST_CORE].req   = core_req_i;
  assign host_bus[HOST_CORE].addr  = core_addr_i;
  assign host_bus[HOST_CORE].we    = core_we_i;
  assign host_bus[HOST_CORE].be    = core_be_i;
  assign host_bus[HOST_CORE].wdata = core_wdata_i;
  assign core_gnt_o    = host_bus[HOST_CORE].gnt;
  assign core_rvalid_o = host_bus[HOST_CORE].rvalid;
  assign core_rdata_o  = host_bus[HOST_CORE].rdata;
  assign core_err_o    = host_bus[HOST_CORE].err;

  // Debug system-bus port
  assign host_bus[HOST_DBG].req   = dbg_req_i;
  assign host_bus[HOST_DBG].addr  = dbg_addr_i;
  assign host_bus[HOST_DBG].we    = dbg_we_i;
  assign host_bus[HOST_DBG].be    = dbg_be_i;
  assign host_bus[HOST_DBG].wdata = dbg_wdata_i;
  assign dbg_gnt_o    = host_bus[HOST_DBG].gnt;
  assign dbg_rvalid_o = host_bus[HOST_DBG].rvalid;
  assign dbg_rdata_o  = host_bus[HOST_DBG].rdata;
  assign dbg_err_o    = host_bus[HOST_DBG].err;

  bus_arbiter u_bus_arbiter (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .hosts_io   (host_bus),
    .devs_io    (dev_bus)
  );

  ram_device #(
    .DEPTH_WORDS (RAM_SIZE / BE_W)
  ) u_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_io     (dev_bus[DEV_RAM])
  );

  gpio_device u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_io     (dev_bus[DEV_GPIO]),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_device u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_io      (dev_bus[DEV_TIMER]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
// Testbench clock with a 4 ns period and a reset held low for 3 cycles
// Reset is released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_sys_o,
  output logic rst_sys_no
);

  localparam int HALF_PERIOD_NS = 2;
  localparam int RST_CYCLES     = 3;

  initial begin
    clk_sys_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_sys_o = ~clk_sys_o;
  end

  initial begin
    rst_sys_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_sys_o);
    @(negedge clk_sys_o);
    rst_sys_no = 1'b1;
  end

endmodule

// ==== tb/demo_system_chk.sv ====
// Grant and response timing checks on both host ports
// Assumes the one-cycle response of the bus arbiter
`timescale 1ns/1ps

module demo_system_chk (
  input logic clk_sys_i,
  input logic rst_sys_ni,
  input logic core_req_i,
  input logic core_gnt_i,
  input logic core_rvalid_i,
  input logic core_err_i,
  input logic dbg_req_i,
  input logic dbg_gnt_i,
  input logic dbg_rvalid_i,
  input logic dbg_err_i
);

  int unsigned pos_fails = 0; // Failures of the rising-edge checks
  int unsigned neg_fails = 0;

  logic core_gnt_q;
  logic dbg_gnt_q;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      core_gnt_q <= 1'b0;
      dbg_gnt_q  <= 1'b0;
    end else begin
      core_gnt_q <= core_gnt_i;
      dbg_gnt_q  <= dbg_gnt_i;
    end
  end

  // Grants follow req combinationally, stable at the rising edge
  gnt_onehot_a: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !(core_gnt_i && dbg_gnt_i))
  else begin
    $error("core and debug hosts granted in the same cycle");
    pos_fails++;
  end

  gnt_has_req_a: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    (!core_gnt_i || core_req_i) && (!dbg_gnt_i || dbg_req_i))
  else begin
    $error("grant without a request");
    pos_fails++;
  end

  core_priority_a: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    core_req_i |-> !dbg_gnt_i)
  else begin
    $error("debug host granted while the core requests");
    pos_fails++;
  end

  // Responses are registered, so they are stable at the falling edge
  rsp_timing_a: assert property (@(negedge clk_sys_i) disable iff (!rst_sys_ni)
    (core_rvalid_i == core_gnt_q) && (dbg_rvalid_i == dbg_gnt_q))
  else begin
    $error("rvalid does not follow the grant by exactly one cycle");
    neg_fails++;
  end

  err_in_rsp_a: assert property (@(negedge clk_sys_i) disable iff (!rst_sys_ni)
    (!core_err_i || core_rvalid_i) && (!dbg_err_i || dbg_rvalid_i))
  else begin
    $error("err raised outside a response");
    neg_fails++;
  end

endmodule

bind demo_system demo_system_chk u_chk (
  .clk_sys_i     (clk_sys_i),
  .rst_sys_ni    (rst_sys_ni),
  .core_req_i    (core_req_i),
  .core_gnt_i    (core_gnt_o),
  .core_rvalid_i (core_rvalid_o),
  .core_err_i    (core_err_o),
  .dbg_req_i     (dbg_req_i),
  .dbg_gnt_i     (dbg_gnt_o),
  .dbg_rvalid_i  (dbg_rvalid_o),
  .dbg_err_i     (dbg_err_o)
);

// ==== tb/demo_system_tb.sv ====
// Directed tests with random data for the two-host bus system
// Inputs change and responses are sampled on the falling edge
`timescale 1ns/1ps

module demo_system_tb import bus_map_pkg::*, periph_pkg::*; ();

  localparam int TEST_CYCLES = 600;                 // Budget of all tests
  localparam int MAX_CYCLES  = TEST_CYCLES * 10 / 3; // Watchdog limit
  localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 32'h4000_0000;

  logic clk_sys;
  logic rst_sys_n;

  logic              req    [NR_HOSTS];
  logic              gnt    [NR_HOSTS];
  logic [ADDR_W-1:0] addr   [NR_HOSTS];
  logic              we     [NR_HOSTS];
  logic [BE_W-1:0]   be     [NR_HOSTS];
  logic [DATA_W-1:0] wdata  [NR_HOSTS];
  logic              rvalid [NR_HOSTS];
  logic [DATA_W-1:0] rdata  [NR_HOSTS];
  logic              err    [NR_HOSTS];
  logic [GPI_W-1:0]  gp_i;
  logic [GPO_W-1:0]  gp_o;
  logic              timer_irq;

  logic [DATA_W-1:0] ram_model [int]; // Word index to contents
  logic [DATA_W-1:0] gpo_model;       // Expected gp_o zero-extended
  logic [DATA_W-1:0] cmp_model;
  int                gnt_cyc [NR_HOSTS];
  int                cycle_cnt = 0;
  int                err_cnt   = 0;

  tb_clk_gen u_clk_gen (
    .clk_sys_o  (clk_sys),
    .rst_sys_no (rst_sys_n)
  );

  demo_system u_dut (
    .clk_sys_i     (clk_sys),
    .rst_sys_ni    (rst_sys_n),
    .core_req_i    (req[HOST_CORE]),
    .core_gnt_o    (gnt[HOST_CORE]),
    .core_addr_i   (addr[HOST_CORE]),
    .core_we_i     (we[HOST_CORE]),
    .core_be_i     (be[HOST_CORE]),
    .core_wdata_i  (wdata[HOST_CORE]),
    .core_rvalid_o (rvalid[HOST_CORE]),
    .core_rdata_o  (rdata[HOST_CORE]),
    .core_err_o    (err[HOST_CORE]),
    .dbg_req_i     (req[HOST_DBG]),
    .dbg_gnt_o     (gnt[HOST_DBG]),
    .dbg_addr_i    (addr[HOST_DBG]),
    .dbg_we_i      (we[HOST_DBG]),
    .dbg_be_i      (be[HOST_DBG]),
    .dbg_wdata_i   (wdata[HOST_DBG]),
    .dbg_rvalid_o  (rvalid[HOST_DBG]),
    .dbg_rdata_o   (rdata[HOST_DBG]),
    .dbg_err_o     (err[HOST_DBG]),
    .gp_i          (gp_i),
    .gp_o          (gp_o),
    .timer_irq_o   (timer_irq)
  );

  always @(posedge clk_sys) cycle_cnt <= cycle_cnt + 1;

  function automatic string host_name(input int h);
    return (h == 0) ? "core" : "dbg";
  endfunction

  // Bytes of new_w selected by lanes replace those of old_w
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [BE_W-1:0]   lanes);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < BE_W; b++) begin
      mask[8*b +: 8] = {8{lanes[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic check_eq(input string sig, input logic [DATA_W-1:0] act,
                          input logic [DATA_W-1:0] exp);
    assert (act === exp)
    else begin
      $display("ERR t=%0t %s expected %h actual %h", $time, sig, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string sig, input logic act, input logic exp);
    assert (act === exp)
    else begin
      $display("ERR t=%0t %s expected %b actual %b", $time, sig, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else begin
      $display("Check failed at %0t: %s", $time, what);
      err_cnt++;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    int chk_fails;
    chk_fails = int'(u_dut.u_chk.pos_fails + u_dut.u_chk.neg_fails);
    $display("Error counts: checks %0d, assertions %0d, timeout %0d",
             err_cnt, chk_fails, timed_out);
    if (!timed_out && err_cnt == 0 && chk_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Starts at a falling edge and returns at the one that carries the response
  task automatic bus_access(input int h, input logic [ADDR_W-1:0] a, input logic w,
                            input logic [BE_W-1:0] lanes, input logic [DATA_W-1:0] wd,
                            output logic [DATA_W-1:0] rd, output logic e);
    logic granted;
    req[h]   = 1'b1;
    addr[h]  = a;
    we[h]    = w;
    be[h]    = lanes;
    wdata[h] = wd;
    granted  = 1'b0;
    while (!granted) begin
      @(posedge clk_sys);
      granted = gnt[h]; // Held since the falling edge
    end
    gnt_cyc[h] = cycle_cnt;
    @(negedge clk_sys);
    req[h] = 1'b0;
    check_bit({host_name(h), "_rvalid_o"}, rvalid[h], 1'b1);
    rd = rdata[h];
    e  = err[h];
  endtask

  task automatic ram_write(input int h, input int idx, input logic [DATA_W-1:0] data,
                           input logic [BE_W-1:0] lanes);
    logic [DATA_W-1:0] rd;
    logic              e;
    bus_access(h, RAM_START + 32'(4 * idx), 1'b1, lanes, data, rd, e);
    ram_model[idx] = merge_bytes(ram_model.exists(idx) ? ram_model[idx] : '0, data, lanes);
    check_bit({host_name(h), "_err_o"}, e, 1'b0);
  endtask

  task automatic ram_read(input int h, input int idx);
    logic [DATA_W-1:0] rd;
    logic              e;
    bus_access(h, RAM_START + 32'(4 * idx), 1'b0, 4'hf, '0, rd, e);
    check_eq({host_name(h), "_rdata_o"}, rd, ram_model[idx]);
    check_bit({host_name(h), "_err_o"}, e, 1'b0);
  endtask

  task automatic gpio_write(input logic [DATA_W-1:0] data, input logic [BE_W-1:0] lanes);
    logic [DATA_W-1:0] rd;
    logic              e;
    bus_access(HOST_CORE, GPIO_START + 32'(GPIO_OUT_OFS), 1'b1, lanes, data, rd, e);
    gpo_model = merge_bytes(gpo_model, data, lanes) & 32'({GPO_W{1'b1}});
    check_eq("gp_o", 32'(gp_o), gpo_model);
    check_bit("core_err_o", e, 1'b0);
  endtask

  initial begin : watchdog
    wait (cycle_cnt >= MAX_CYCLES);
    $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
    finish_run(1'b1);
  end

  initial begin : main
    logic [DATA_W-1:0] rd;
    logic              e;
    int                start;
    int                prev_gnt;
    int                low_reads;

    for (int h = 0; h < NR_HOSTS; h++) begin
      req[h]   = 1'b0;
      addr[h]  = '0;
      we[h]    = 1'b0;
      be[h]    = '0;
      wdata[h] = '0;
    end
    gp_i      = '0;
    gpo_model = '0;
    cmp_model = TIMER_CMP_RESET;
    void'($urandom(41051));
    wait (rst_sys_n === 1'b1);
    @(negedge clk_sys);
    check_bit("timer_irq_o", timer_irq, 1'b0);
    check_eq("gp_o", 32'(gp_o), gpo_model);

    // Full RAM words and then single bytes over them
    for (int i = 0; i < 8; i++) ram_write(HOST_CORE, i, $urandom(), 4'hf);
    for (int i = 0; i < 8; i++) ram_write(HOST_CORE, i, $urandom(), 4'b0001 << (i % 4));
    ram_write(HOST_CORE, 3, $urandom(), 4'b0110);

    prev_gnt = 0;
    for (int i = 0; i < 8; i++) begin
      ram_read(HOST_CORE, i); // One read per cycle
      if (i > 0) begin
        check_true(gnt_cyc[HOST_CORE] == prev_gnt + 1, "core reads not granted back to back");
      end
      prev_gnt = gnt_cyc[HOST_CORE];
    end

    // Both hosts at once while the core holds req over two accesses
    fork
      begin
        ram_write(HOST_CORE, 20, $urandom(), 4'hf);
        ram_read(HOST_CORE, 20);
      end
      ram_write(HOST_DBG, 21, $urandom(), 4'hf);
    join
    check_true(gnt_cyc[HOST_DBG] == gnt_cyc[HOST_CORE] + 1,
               "debug host not granted right after the core dropped req");
    fork
      ram_read(HOST_CORE, 21);
      ram_read(HOST_DBG, 20);
    join
    check_true(gnt_cyc[HOST_DBG] == gnt_cyc[HOST_CORE] + 1,
               "debug read not granted right after the core read");
    ram_read(HOST_DBG, 5);

    // Lanes above GPO_W leave gp_o unchanged
    gpio_write($urandom(), 4'b0011);
    gpio_write($urandom(), 4'b0010);
    gpio_write($urandom(), 4'b0101);
    gpio_write($urandom(), 4'b1100);
    bus_access(HOST_CORE, GPIO_START + 32'(GPIO_OUT_OFS), 1'b0, 4'hf, '0, rd, e);
    check_eq("core_rdata_o", rd, gpo_model);
    for (int i = 0; i < 2; i++) begin
      gp_i = 8'($urandom());
      repeat (3) @(negedge clk_sys); // Let the synchronizer settle
      bus_access(HOST_CORE, GPIO_START + 32'(GPIO_IN_OFS), 1'b0, 4'hf, '0, rd, e);
      check_eq("core_rdata_o", rd, 32'(gp_i));
    end

    // Compare value out of reset
    bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIMECMP_OFS), 1'b0, 4'hf, '0, rd, e);
    check_eq("core_rdata_o", rd, cmp_model);

    // Timer compare at 50
    bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIME_OFS), 1'b1, 4'hf, '0, rd, e);
    cmp_model = 32'd50;
    bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIMECMP_OFS), 1'b1, 4'hf, cmp_model, rd, e);
    start     = cycle_cnt;
    low_reads = 0;
    while (timer_irq !== 1'b1 && cycle_cnt - start < 60) begin
      bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIME_OFS), 1'b0, 4'hf, '0, rd, e);
      if (rd < 50) begin
        low_reads++;
        check_bit("timer_irq_o", timer_irq, 1'b0);
      end
    end
    check_true(low_reads > 0, "mtime not restarted from zero by the bus write");
    check_true(timer_irq === 1'b1, "timer interrupt not raised within 60 cycles");
    bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIMECMP_OFS), 1'b0, 4'hf, '0, rd, e);
    check_eq("core_rdata_o", rd, cmp_model);
    cmp_model = TIMER_CMP_RESET;
    bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIMECMP_OFS), 1'b1, 4'hf, cmp_model, rd, e);
    bus_access(HOST_CORE, TIMER_START + 32'(TIMER_MTIMECMP_OFS), 1'b0, 4'hf, '0, rd, e);
    check_eq("core_rdata_o", rd, cmp_model);
    check_bit("timer_irq_o", timer_irq, 1'b0); // Irq lags the compare by one cycle

    // Error responses
    bus_access(HOST_CORE, UNMAPPED_ADDR, 1'b0, 4'hf, '0, rd, e);
    check_bit("core_err_o", e, 1'b1);
    check_eq("core_rdata_o", rd, '0);
    bus_access(HOST_DBG, UNMAPPED_ADDR, 1'b1, 4'hf, $urandom(), rd, e);
    check_bit("dbg_err_o", e, 1'b1);
    check_eq("dbg_rdata_o", rd, '0);
    bus_access(HOST_CORE, TIMER_START + 32'h10, 1'b0, 4'hf, '0, rd, e);
    check_bit("core_err_o", e, 1'b1);
    ram_read(HOST_CORE, 2);
    ram_read(HOST_DBG, 3);

    finish_run(1'b0);
  end

endmodule

// ==== compile.f ====
rtl/bus_map_pkg.sv
rtl/periph_pkg.sv
rtl/bus_if.sv
rtl/bus_arbiter.sv
rtl/ram_device.sv
rtl/gpio_device.sv
rtl/timer_device.sv
rtl/demo_system.sv
tb/tb_clk_gen.sv
tb/demo_system_chk.sv
tb/demo_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the demo_system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module demo_system_tb -f compile.f -o demo_system_tb

out=$(./obj_dir/demo_system_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
